//--- common/acc_pkg.sv
/*
 * Accumulator unit package
 * Widths, operation codes and sequencer state encodings
 */

package acc_pkg;

   // Datapath widths
   localparam int data_w  = 32;   // Accumulator and shifter
   localparam int half_w  = 16;   // Multiplier operands
   localparam int shamt_w = 6;    // Signed shift amount, bit 5 set means right

   // Shift-add iterations for a 16x16 product
   localparam int mult_steps = 16;

   // Accumulator operations
   typedef enum logic [1:0] {
      op_load  = 2'b00,
      op_add   = 2'b01,
      op_shift = 2'b10,
      op_mac   = 2'b11
   } op_t;

   // Shifter and multiplier sequence
   typedef enum logic [1:0] {
      st_idle    = 2'b00,
      st_running = 2'b01,
      st_last    = 2'b10
   } seq_state_t;

   // Command sequencer
   typedef enum logic [1:0] {
      cs_idle       = 2'b00,
      cs_wait_shift = 2'b01,
      cs_wait_mult  = 2'b10,
      cs_finish     = 2'b11
   } ctrl_state_t;

endpackage

//--- hw/shift_unit/shift_unit.sv
/*
 * Iterative left/arithmetic-right shifter, one bit per cycle
 * Reports last bit out and sticky sign changes at bits 15 and 31
 */

`timescale 1ns/100ps

module shift_unit (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        ready,
   input  logic [acc_pkg::data_w-1:0]  data_in,
   input  logic [acc_pkg::shamt_w-1:0] shift_amount,
   output logic                        done,
   output logic [acc_pkg::data_w-1:0]  data_out,
   output logic                        last_bit,
   output logic                        sign_change16,
   output logic                        sign_change32
);
   import acc_pkg::*;

   seq_state_t         state;
   seq_state_t         next_state;
   logic [shamt_w-1:0] count;
   logic               up;
   logic               final_step;

   // Direction comes from the sign of the loaded count
   assign up = ~count[shamt_w-1];

   // Left counts down to 1, right counts up to -1
   assign final_step = up ? (count < shamt_w'(2)) : (count == {shamt_w{1'b1}});

   assign done = (state == st_last);

   always_comb
   begin
      next_state = state;
      case (state)
         st_idle:
            if (ready)
               next_state = st_running;
         st_running:
            if (final_step)
               next_state = st_last;
         st_last:
            if (!ready)
               next_state = st_idle;   // Hold done until ready falls
         default:
            next_state = st_idle;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= st_idle;
         count <= '0;
      end
      else
      begin
         state <= next_state;
         if (state == st_idle)
            count <= shift_amount;
         else if (state == st_running && count != '0)
            count <= up ? count - shamt_w'(1) : count + shamt_w'(1);
      end
   end

   always_ff @(posedge clk)
   begin
      if (state == st_idle)
      begin
         data_out      <= data_in;
         last_bit      <= 1'b0;
         sign_change16 <= 1'b0;
         sign_change32 <= 1'b0;
      end
      else if (state == st_running && count != '0)   // Zero shift passes through
      begin
         if (up)
         begin
            last_bit <= data_out[data_w-1];
            data_out <= {data_out[data_w-2:0], 1'b0};
            // Sticky, checked before the step
            if (data_out[15] ^ data_out[14])
               sign_change16 <= 1'b1;
            if (data_out[31] ^ data_out[30])
               sign_change32 <= 1'b1;
         end
         else
         begin
            last_bit <= data_out[0];
            data_out <= {data_in[data_w-1], data_out[data_w-1:1]};   // Sign fill
         end
      end
   end

   // A second done cycle needs ready held through the first
   a_done_needs_ready: assert property (@(posedge clk) disable iff (reset)
      (done && !ready) |=> !done);

   a_result_stable: assert property (@(posedge clk) disable iff (reset)
      (state == st_last) |=> $stable(data_out));

endmodule

//--- hw/mult_unit/mult_unit.sv
/*
 * Iterative 16x16 unsigned shift-add multiplier
 * Same ready/done sequence as the shifter
 */

`timescale 1ns/100ps

module mult_unit (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       ready,
   input  logic [acc_pkg::half_w-1:0] multiplicand,
   input  logic [acc_pkg::half_w-1:0] multiplier,
   output logic                       done,
   output logic [acc_pkg::data_w-1:0] product
);
   import acc_pkg::*;

   seq_state_t        state;
   seq_state_t        next_state;
   logic [4:0]        step;
   logic [data_w-1:0] mcand;      // Shifts left each step
   logic [half_w-1:0] mplier;     // Shifts right each step
   logic [data_w-1:0] partial;

   assign done    = (state == st_last);
   assign product = partial;

   always_comb
   begin
      next_state = state;
      case (state)
         st_idle:
            if (ready)
               next_state = st_running;
         st_running:
            if (step == 5'(mult_steps - 1))
               next_state = st_last;
         st_last:
            if (!ready)
               next_state = st_idle;
         default:
            next_state = st_idle;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= st_idle;
         step  <= '0;
      end
      else
      begin
         state <= next_state;
         if (state == st_idle)
            step <= '0;
         else if (state == st_running)
            step <= step + 5'd1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (state == st_idle)
      begin
         mcand   <= {{half_w{1'b0}}, multiplicand};
         mplier  <= multiplier;
         partial <= '0;
      end
      else if (state == st_running)
      begin
         if (mplier[0])
            partial <= partial + mcand;
         mcand  <= {mcand[data_w-2:0], 1'b0};
         mplier <= {1'b0, mplier[half_w-1:1]};
      end
   end

   a_step_bound: assert property (@(posedge clk) disable iff (reset)
      step <= 5'(mult_steps));

endmodule

//--- hw/acc_ctrl.sv
/*
 * Command sequencer for the accumulator unit
 * Owns accumulator and flags, launches shifter and multiplier
 */

`timescale 1ns/100ps

module acc_ctrl (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        op_start,
   input  acc_pkg::op_t                op_code,
   input  logic [acc_pkg::data_w-1:0]  operand,
   input  logic [acc_pkg::shamt_w-1:0] shift_amount,
   output logic                        busy,
   output logic                        op_done,
   output logic [acc_pkg::data_w-1:0]  acc_value,
   output logic                        carry_out,
   output logic                        ovf16,
   output logic                        ovf32,
   output logic                        shift_ready,
   output logic [acc_pkg::data_w-1:0]  shift_data,
   output logic [acc_pkg::shamt_w-1:0] shift_count,
   input  logic                        shift_done,
   input  logic [acc_pkg::data_w-1:0]  shift_result,
   input  logic                        shift_last_bit,
   input  logic                        shift_sign16,
   input  logic                        shift_sign32,
   output logic                        mult_ready,
   output logic [acc_pkg::half_w-1:0]  mult_a,
   output logic [acc_pkg::half_w-1:0]  mult_b,
   input  logic                        mult_done,
   input  logic [acc_pkg::data_w-1:0]  mult_product
);
   import acc_pkg::*;

   ctrl_state_t        state;
   op_t                cmd_op;
   logic [data_w-1:0]  cmd_operand;
   logic [shamt_w-1:0] cmd_shamt;
   logic [data_w-1:0]  addend;
   logic [data_w:0]    sum;
   logic               add_ovf;

   assign busy = (state != cs_idle);

   // Latched command drives both units for the whole operation
   assign shift_data  = acc_value;
   assign shift_count = cmd_shamt;
   assign mult_a      = cmd_operand[data_w-1:half_w];
   assign mult_b      = cmd_operand[half_w-1:0];

   // Shared adder for add and multiply-accumulate
   assign addend  = (state == cs_wait_mult) ? mult_product : cmd_operand;
   assign sum     = {1'b0, acc_value} + {1'b0, addend};
   assign add_ovf = (acc_value[data_w-1] == addend[data_w-1]) &&
                    (sum[data_w-1] != acc_value[data_w-1]);

   always_ff @(posedge clk)
   begin
      if (state == cs_idle && op_start)
      begin
         cmd_op      <= op_code;
         cmd_operand <= operand;
         cmd_shamt   <= shift_amount;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state       <= cs_idle;
         shift_ready <= 1'b0;
         mult_ready  <= 1'b0;
         op_done     <= 1'b0;
         acc_value   <= '0;
         carry_out   <= 1'b0;
         ovf16       <= 1'b0;
         ovf32       <= 1'b0;
      end
      else
      begin
         op_done <= 1'b0;
         case (state)
            cs_idle:
               if (op_start)
               begin
                  case (op_code)
                     op_shift:
                     begin
                        state       <= cs_wait_shift;
                        shift_ready <= 1'b1;
                     end
                     op_mac:
                     begin
                        state      <= cs_wait_mult;
                        mult_ready <= 1'b1;
                     end
                     default:
                        state <= cs_finish;   // Load and add finish next cycle
                  endcase
               end
            cs_finish:
            begin
               state   <= cs_idle;
               op_done <= 1'b1;
               if (cmd_op == op_load)
               begin
                  acc_value <= cmd_operand;
                  carry_out <= 1'b0;
                  ovf16     <= 1'b0;
                  ovf32     <= 1'b0;
               end
               else
               begin
                  acc_value <= sum[data_w-1:0];
                  carry_out <= sum[data_w];
                  ovf32     <= ovf32 | add_ovf;
               end
            end
            cs_wait_shift:
               if (shift_done)
               begin
                  state       <= cs_idle;
                  shift_ready <= 1'b0;   // Keeps done to one cycle
                  op_done     <= 1'b1;
                  acc_value   <= shift_result;
                  carry_out   <= shift_last_bit;
                  ovf16       <= ovf16 | shift_sign16;
                  ovf32       <= ovf32 | shift_sign32;
               end
            cs_wait_mult:
               if (mult_done)
               begin
                  state      <= cs_idle;
                  mult_ready <= 1'b0;
                  op_done    <= 1'b1;
                  acc_value  <= sum[data_w-1:0];
                  carry_out  <= sum[data_w];
                  ovf32      <= ovf32 | add_ovf;
               end
            default:
               state <= cs_idle;
         endcase
      end
   end

   a_done_pulse: assert property (@(posedge clk) disable iff (reset)
      op_done |=> !op_done);

   // Only one unit runs at a time
   a_one_unit: assert property (@(posedge clk) disable iff (reset)
      !(shift_ready && mult_ready));

endmodule

//--- hw/acc_unit.sv
/*
 * Accumulator unit top level
 * Controller with shifter and multiplier
 */

`timescale 1ns/100ps

module acc_unit (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        op_start,
   input  acc_pkg::op_t                op_code,
   input  logic [acc_pkg::data_w-1:0]  operand,
   input  logic [acc_pkg::shamt_w-1:0] shift_amount,
   output logic                        busy,
   output logic                        op_done,
   output logic [acc_pkg::data_w-1:0]  acc_value,
   output logic                        carry_out,
   output logic                        ovf16,
   output logic                        ovf32
);
   import acc_pkg::*;

   // Controller to shifter
   logic               shift_ready;
   logic [data_w-1:0]  shift_data;
   logic [shamt_w-1:0] shift_count;
   logic               shift_done;
   logic [data_w-1:0]  shift_result;
   logic               shift_last_bit;
   logic               shift_sign16;
   logic               shift_sign32;

   // Controller to multiplier
   logic               mult_ready;
   logic [half_w-1:0]  mult_a;
   logic [half_w-1:0]  mult_b;
   logic               mult_done;
   logic [data_w-1:0]  mult_product;

   acc_ctrl i_ctrl (
      .clk            (clk),
      .reset          (reset),
      .op_start       (op_start),
      .op_code        (op_code),
      .operand        (operand),
      .shift_amount   (shift_amount),
      .busy           (busy),
      .op_done        (op_done),
      .acc_value      (acc_value),
      .carry_out      (carry_out),
      .ovf16          (ovf16),
      .ovf32          (ovf32),
      .shift_ready    (shift_ready),
      .shift_data     (shift_data),
      .shift_count    (shift_count),
      .shift_done     (shift_done),
      .shift_result   (shift_result),
      .shift_last_bit (shift_last_bit),
      .shift_sign16   (shift_sign16),
      .shift_sign32   (shift_sign32),
      .mult_ready     (mult_ready),
      .mult_a         (mult_a),
      .mult_b         (mult_b),
      .mult_done      (mult_done),
      .mult_product   (mult_product)
   );

   shift_unit i_shift (
      .clk           (clk),
      .reset         (reset),
      .ready         (shift_ready),
      .data_in       (shift_data),
      .shift_amount  (shift_count),
      .done          (shift_done),
      .data_out      (shift_result),
      .last_bit      (shift_last_bit),
      .sign_change16 (shift_sign16),
      .sign_change32 (shift_sign32)
   );

   mult_unit i_mult (
      .clk          (clk),
      .reset        (reset),
      .ready        (mult_ready),
      .multiplicand (mult_a),
      .multiplier   (mult_b),
      .done         (mult_done),
      .product      (mult_product)
   );

endmodule

//--- bench/tb_clock.sv
/*
 * Testbench clock with an 8 ns period
 * Reset held high for the first 3 cycles
 */

`timescale 1ns/100ps

module tb_clock (
   output logic clk,
   output logic reset
);
   localparam int half_period = 4;
   localparam int reset_cycles = 3;

   initial
   begin
      clk = 1'b0;
      forever #half_period clk = ~clk;
   end

   initial
   begin
      reset = 1'b1;
      repeat (reset_cycles) @(posedge clk);
      reset <= 1'b0;   // Released on the third edge
   end

endmodule

//--- bench/acc_unit_tb.sv
/*
 * Testbench top for the accumulator unit
 * LFSR stimulus, reference model, concurrent checks, timeout and summary
 */

`timescale 1ns/100ps

module acc_unit_tb;
   import acc_pkg::*;

   localparam int n_directed   = 8;
   localparam int n_random     = 200;
   localparam int n_cmds       = n_directed + n_random;
   localparam int reset_cycles = 3;
   localparam int cycle_limit  = n_cmds * 40 + reset_cycles;

   logic               clk;
   logic               reset;
   logic               op_start;
   op_t                op_code;
   logic [data_w-1:0]  operand;
   logic [shamt_w-1:0] shift_amount;
   logic               busy;
   logic               op_done;
   logic [data_w-1:0]  acc_value;
   logic               carry_out;
   logic               ovf16;
   logic               ovf32;

   // Reference model state
   logic [data_w-1:0]  exp_acc;
   logic               exp_carry;
   logic               exp_ovf16;
   logic               exp_ovf32;

   logic [31:0]        lfsr;
   logic               started;
   int                 issued;
   int                 done_seen;
   int                 errors = 0;
   int                 timeouts;
   int                 cycle_count;

   tb_clock i_clock (
      .clk   (clk),
      .reset (reset)
   );

   acc_unit i_dut (
      .clk          (clk),
      .reset        (reset),
      .op_start     (op_start),
      .op_code      (op_code),
      .operand      (operand),
      .shift_amount (shift_amount),
      .busy         (busy),
      .op_done      (op_done),
      .acc_value    (acc_value),
      .carry_out    (carry_out),
      .ovf16        (ovf16),
      .ovf32        (ovf32)
   );

   // Fibonacci LFSR, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   task automatic draw_bits(input int n, output logic [31:0] value);
      int i;
      value = '0;
      for (i = 0; i < n; i++)
      begin
         lfsr  = lfsr_next(lfsr);
         value = {value[30:0], lfsr[0]};
      end
   endtask

   // Bits outside 31..0 read as zero
   function automatic logic bit_at(input logic [31:0] value, input int pos);
      logic [31:0] tmp;
      if (pos < 0 || pos > 31)
         return 1'b0;
      tmp = value >> pos;
      return tmp[0];
   endfunction

   task automatic apply_add(input logic [31:0] b);
      logic [32:0] total;
      total = {1'b0, exp_acc} + {1'b0, b};
      if (exp_acc[31] == b[31] && total[31] != exp_acc[31])
         exp_ovf32 = 1'b1;   // Sticky
      exp_carry = total[32];
      exp_acc   = total[31:0];
   endtask

   task automatic predict(input op_t op, input logic [31:0] value, input logic [5:0] amount);
      logic [31:0] product;
      logic [63:0] wide;
      int          k;
      int          m;
      int          i;
      case (op)
         op_load:
         begin
            exp_acc   = value;
            exp_carry = 1'b0;
            exp_ovf16 = 1'b0;
            exp_ovf32 = 1'b0;
         end
         op_add:
            apply_add(value);
         op_mac:
         begin
            product = {16'b0, value[31:16]} * {16'b0, value[15:0]};
            apply_add(product);
         end
         default:
         begin
            k = {26'b0, amount};
            if (!amount[5])
            begin
               // Left by k, flags look at bits k positions below the sign bits
               for (i = 31; i >= 31 - k; i--)
                  if (bit_at(exp_acc, i) != exp_acc[31])
                     exp_ovf32 = 1'b1;
               for (i = 15; i >= 15 - k; i--)
                  if (bit_at(exp_acc, i) != exp_acc[15])
                     exp_ovf16 = 1'b1;
               exp_carry = (k == 0) ? 1'b0 : bit_at(exp_acc, 32 - k);
               wide      = {32'b0, exp_acc} << k;
               exp_acc   = wide[31:0];
            end
            else
            begin
               m         = 64 - k;   // Magnitude 1 to 32
               exp_carry = bit_at(exp_acc, m - 1);
               wide      = {{32{exp_acc[31]}}, exp_acc} >> m;
               exp_acc   = wide[31:0];
            end
         end
      endcase
   endtask

   // Hold keeps op_start high with a different command until op_done
   task automatic run_command(input op_t op, input logic [31:0] value,
                              input logic [5:0] amount, input logic hold);
      logic [31:0] junk;
      predict(op, value, amount);
      started      = 1'b1;
      issued       = issued + 1;
      op_start     = 1'b1;
      op_code      = op;
      operand      = value;
      shift_amount = amount;
      @(negedge clk);
      if (hold)
      begin
         draw_bits(32, junk);
         op_code      = op_t'(junk[1:0]);
         operand      = junk;
         shift_amount = junk[5:0];
      end
      else
         op_start = 1'b0;
      while (!op_done)
         @(negedge clk);
      op_start = 1'b0;
      @(negedge clk);
   endtask

   task automatic note_error(input string msg);
      errors = errors + 1;
      $display("FAIL at %0t: %s", $time, msg);
   endtask

   task automatic print_summary();
      $display("Summary: %0d errors, %0d timeouts, %0d commands issued",
               errors, timeouts, issued);
   endtask

   always @(posedge clk)
   begin
      if (reset)
         done_seen <= 0;
      else if (op_done)
         done_seen <= done_seen + 1;
   end

   a_reset_state: assert property (@(posedge clk) disable iff (reset)
      !started |-> (!busy && !op_done && acc_value == '0 && !carry_out && !ovf16 && !ovf32))
      else note_error("outputs not cleared after reset");

   a_acc_value: assert property (@(posedge clk) disable iff (reset)
      op_done |-> acc_value == exp_acc)
      else note_error($sformatf("acc_value %h, expected %h", acc_value, exp_acc));

   a_carry: assert property (@(posedge clk) disable iff (reset)
      op_done |-> carry_out == exp_carry)
      else note_error($sformatf("carry_out %b, expected %b", carry_out, exp_carry));

   a_ovf16: assert property (@(posedge clk) disable iff (reset)
      op_done |-> ovf16 == exp_ovf16)
      else note_error($sformatf("ovf16 %b, expected %b", ovf16, exp_ovf16));

   a_ovf32: assert property (@(posedge clk) disable iff (reset)
      op_done |-> ovf32 == exp_ovf32)
      else note_error($sformatf("ovf32 %b, expected %b", ovf32, exp_ovf32));

   // One op_done per accepted command
   a_one_done: assert property (@(posedge clk) disable iff (reset)
      op_done |-> (done_seen + 1 == issued))
      else note_error($sformatf("op_done number %0d for %0d commands", done_seen + 1, issued));

   a_busy_rises: assert property (@(posedge clk) disable iff (reset)
      (op_start && !busy) |=> busy)
      else note_error("busy not raised after command accepted");

   a_busy_holds: assert property (@(posedge clk) disable iff (reset)
      busy |=> (busy || op_done))
      else note_error("busy dropped without op_done");

   a_done_idle: assert property (@(posedge clk) disable iff (reset)
      op_done |-> !busy)
      else note_error("busy still high with op_done");

   a_no_stray_busy: assert property (@(posedge clk) disable iff (reset)
      (!busy && !op_start) |=> !busy)
      else note_error("busy raised without op_start");

   initial
   begin
      logic [31:0] bits;
      logic [31:0] value;
      logic [31:0] amt_bits;
      int          n;
      op_start     = 1'b0;
      op_code      = op_load;
      operand      = '0;
      shift_amount = '0;
      lfsr         = 32'h2a45_542b;
      started      = 1'b0;
      issued       = 0;
      exp_acc      = '0;
      exp_carry    = 1'b0;
      exp_ovf16    = 1'b0;
      exp_ovf32    = 1'b0;
      repeat (reset_cycles + 1) @(negedge clk);

      // Directed shifts of +31, -32 and 0, the last one with carry set
      run_command(op_load, 32'h8000_4001, 6'd0, 1'b0);
      run_command(op_shift, 32'h0, 6'd31, 1'b0);
      run_command(op_shift, 32'h0, 6'b100000, 1'b0);
      run_command(op_shift, 32'h0, 6'd0, 1'b0);
      run_command(op_load, 32'h7fff_ffff, 6'd0, 1'b0);
      run_command(op_add, 32'h0000_0001, 6'd0, 1'b0);   // Signed overflow
      // Second command held while busy
      run_command(op_shift, 32'h0, 6'h3b, 1'b1);
      run_command(op_mac, 32'hbeef_1234, 6'd0, 1'b1);

      for (n = 0; n < n_random; n++)
      begin
         draw_bits(2, bits);
         draw_bits(32, value);
         draw_bits(6, amt_bits);
         run_command(op_t'(bits[1:0]), value, amt_bits[5:0], 1'b0);
      end

      repeat (2) @(negedge clk);
      print_summary();
      if (errors == 0 && timeouts == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

   initial
   begin
      timeouts    = 0;
      cycle_count = 0;
      while (cycle_count < cycle_limit)
      begin
         @(posedge clk);
         cycle_count = cycle_count + 1;
      end
      timeouts = 1;
      $display("Run timed out after %0d cycles before all commands completed", cycle_count);
      print_summary();
      $display("sim failed");
      $finish;
   end

endmodule

//--- filelist.f
common/acc_pkg.sv
hw/shift_unit/shift_unit.sv
hw/mult_unit/mult_unit.sv
hw/acc_ctrl.sv
hw/acc_unit.sv
bench/tb_clock.sv
bench/acc_unit_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the accumulator unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module acc_unit_tb \
   -f filelist.f -o acc_unit_sim
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

output=$(./obj_dir/acc_unit_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -qx "sim passed"; then
   exit 0
fi
exit 1
